//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = tb_rv_core
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "Verification passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

//--- files.f
hw/rv_pkg.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_regfile.sv
hw/rv_csr.sv
hw/rv_core_top.sv
verification/tb_rv_core.sv

//--- hw/rv_core_top.sv
`default_nettype none

module rv_core_top import rv_pkg::*; #(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  inst_ack_i,
  input  word_t inst_data_i,
  input  logic  mem_ack_i,
  output logic  inst_stb_o,
  output word_t inst_adr_o,
  output logic  mem_req_o,
  output word_t mem_addr_o,
  output word_t mem_data_o
);

  logic       inst_vld;
  word_t      inst_word;
  logic       dec_vld;
  op_class_e  op_class;
  logic [2:0] funct3;
  logic       alt;
  reg_addr_t  rd;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  word_t      imm;
  csr_addr_t  csr_addr;
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      csr_rdata;
  logic       rd_we;
  reg_addr_t  rd_addr;
  word_t      rd_data;
  logic       retire;

  rv_fetch #(.RESET_PC(RESET_PC)) u_fetch (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .retire_i   (retire),
    .inst_ack_i (inst_ack_i),
    .inst_data_i(inst_data_i),
    .inst_stb_o (inst_stb_o),
    .inst_adr_o (inst_adr_o),
    .inst_vld_o (inst_vld),
    .inst_word_o(inst_word)
  );

  rv_decode u_decode (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .inst_vld_i (inst_vld),
    .inst_word_i(inst_word),
    .dec_vld_o  (dec_vld),
    .op_class_o (op_class),
    .funct3_o   (funct3),
    .alt_o      (alt),
    .rd_o       (rd),
    .rs1_o      (rs1),
    .rs2_o      (rs2),
    .imm_o      (imm),
    .csr_addr_o (csr_addr)
  );

  rv_execute u_execute (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .dec_vld_i  (dec_vld),
    .op_class_i (op_class),
    .funct3_i   (funct3),
    .alt_i      (alt),
    .rd_i       (rd),
    .imm_i      (imm),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .csr_rdata_i(csr_rdata),
    .mem_ack_i  (mem_ack_i),
    .rd_we_o    (rd_we),
    .rd_addr_o  (rd_addr),
    .rd_data_o  (rd_data),
    .mem_req_o  (mem_req_o),
    .mem_addr_o (mem_addr_o),
    .mem_data_o (mem_data_o),
    .retire_o   (retire)
  );

  rv_regfile u_regfile (
    .clk       (clk),
    .rs1_i     (rs1),
    .rs2_i     (rs2),
    .we_i      (rd_we),
    .wr_addr_i (rd_addr),
    .wr_data_i (rd_data),
    .rs1_data_o(rs1_data),
    .rs2_data_o(rs2_data)
  );

  rv_csr u_csr (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .retire_i   (retire),
    .csr_addr_i (csr_addr),
    .csr_rdata_o(csr_rdata)
  );

endmodule

`default_nettype wire

//--- hw/rv_csr.sv
`default_nettype none

module rv_csr import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      retire_i,
  input  csr_addr_t csr_addr_i,
  output word_t     csr_rdata_o
);

  dword_t mcycle_q;
  dword_t minstret_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      mcycle_q   <= 64'd0;
      minstret_q <= 64'd0;
    end else begin
      mcycle_q <= mcycle_q + 64'd1;
      if (retire_i) begin
        minstret_q <= minstret_q + 64'd1;
      end
    end
  end

  always_comb begin
    case (csr_addr_i)
      CSR_MCYCLE:    csr_rdata_o = mcycle_q[31:0];
      CSR_MCYCLEH:   csr_rdata_o = mcycle_q[63:32];
      CSR_MINSTRET:  csr_rdata_o = minstret_q[31:0];
      CSR_MINSTRETH: csr_rdata_o = minstret_q[63:32];
      default:       csr_rdata_o = 32'd0; // Unknown CSR reads zero
    endcase
  end

  // Each retirement takes at least one cycle of its own
  a_instret_le_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
    minstret_q <= mcycle_q);

endmodule

`default_nettype wire

//--- hw/rv_decode.sv
`default_nettype none

module rv_decode import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      inst_vld_i,
  input  word_t     inst_word_i,
  output logic      dec_vld_o,
  output op_class_e op_class_o,
  output logic[2:0] funct3_o,
  output logic      alt_o,
  output reg_addr_t rd_o,
  output reg_addr_t rs1_o,
  output reg_addr_t rs2_o,
  output word_t     imm_o,
  output csr_addr_t csr_addr_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       f7_ok;
  word_t      imm_d;
  op_class_e  class_d;

  assign opcode = inst_word_i[6:0];
  assign funct3 = inst_word_i[14:12];
  assign f7_ok  = !inst_word_i[31] && (inst_word_i[29:25] == 5'd0); // 0x00 or 0x20

  always_comb begin
    imm_d   = {{20{inst_word_i[31]}}, inst_word_i[31:20]}; // I-type
    class_d = OP_NOP;
    case (opcode)
      OPC_OP_IMM: begin
        class_d = OP_ALU_IMM;
      end
      OPC_OP: begin
        if (f7_ok) begin
          class_d = OP_ALU_REG;
        end
      end
      OPC_LUI: begin
        imm_d   = {inst_word_i[31:12], 12'd0};
        class_d = OP_LUI;
      end
      OPC_STORE: begin
        imm_d = {{20{inst_word_i[31]}}, inst_word_i[31:25], inst_word_i[11:7]};
        if (funct3 == F3_SW) begin
          class_d = OP_STORE;
        end
      end
      OPC_SYSTEM: begin
        // Only plain counter reads
        if (funct3 == F3_CSRRS && inst_word_i[19:15] == 5'd0) begin
          class_d = OP_CSR_READ;
        end
      end
      default: begin
        class_d = OP_NOP;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      dec_vld_o <= 1'b0;
    end else begin
      dec_vld_o <= inst_vld_i;
    end
  end

  always_ff @(posedge clk) begin
    if (inst_vld_i) begin
      op_class_o <= class_d;
      funct3_o   <= funct3;
      alt_o      <= inst_word_i[30]; // SUB, SRA, SRAI
      rd_o       <= inst_word_i[11:7];
      rs1_o      <= inst_word_i[19:15];
      rs2_o      <= inst_word_i[24:20];
      imm_o      <= imm_d;
      csr_addr_o <= inst_word_i[31:20];
    end
  end

endmodule

`default_nettype wire

//--- hw/rv_execute.sv
`default_nettype none

module rv_execute import rv_pkg::*; (
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic       dec_vld_i,
  input  op_class_e  op_class_i,
  input  logic [2:0] funct3_i,
  input  logic       alt_i,
  input  reg_addr_t  rd_i,
  input  word_t      imm_i,
  input  word_t      rs1_data_i,
  input  word_t      rs2_data_i,
  input  word_t      csr_rdata_i,
  input  logic       mem_ack_i,
  output logic       rd_we_o,
  output reg_addr_t  rd_addr_o,
  output word_t      rd_data_o,
  output logic       mem_req_o,
  output word_t      mem_addr_o,
  output word_t      mem_data_o,
  output logic       retire_o
);

  exec_state_e state_q;
  word_t       op_b;
  word_t       alu_res;
  logic [4:0]  shamt;
  logic        is_reg;
  word_t       mem_addr_q;
  word_t       mem_data_q;

  // ========================================
  // ALU
  // ========================================
  assign is_reg = (op_class_i == OP_ALU_REG);
  assign op_b   = is_reg ? rs2_data_i : imm_i;
  assign shamt  = op_b[4:0];

  always_comb begin
    case (funct3_i)
      F3_ADD:  alu_res = (is_reg && alt_i) ? rs1_data_i - op_b : rs1_data_i + op_b;
      F3_SLL:  alu_res = rs1_data_i << shamt;
      F3_SLT:  alu_res = {31'd0, $signed(rs1_data_i) < $signed(op_b)};
      F3_SLTU: alu_res = {31'd0, rs1_data_i < op_b};
      F3_XOR:  alu_res = rs1_data_i ^ op_b;
      F3_SR:   alu_res = alt_i ? word_t'($signed(rs1_data_i) >>> shamt) : rs1_data_i >> shamt;
      F3_OR:   alu_res = rs1_data_i | op_b;
      default: alu_res = rs1_data_i & op_b;
    endcase
  end

  // Writeback lands on the edge that raises retire
  always_comb begin
    case (op_class_i)
      OP_LUI:      rd_data_o = imm_i;
      OP_CSR_READ: rd_data_o = csr_rdata_i;
      default:     rd_data_o = alu_res;
    endcase
  end

  assign rd_we_o   = dec_vld_i && (op_class_i inside {OP_ALU_IMM, OP_ALU_REG,
                                                      OP_LUI, OP_CSR_READ});
  assign rd_addr_o = rd_i;

  // ========================================
  // Sequencing and store
  // ========================================
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= EXEC_IDLE;
    end else begin
      case (state_q)
        EXEC_IDLE: begin
          if (dec_vld_i) begin
            state_q <= (op_class_i == OP_STORE) ? EXEC_STORE : EXEC_RETIRE;
          end
        end
        EXEC_STORE: begin
          if (mem_ack_i) begin
            state_q <= EXEC_RETIRE;
          end
        end
        default: begin
          state_q <= EXEC_IDLE; // Retire lasts one cycle
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (dec_vld_i && op_class_i == OP_STORE) begin
      mem_addr_q <= rs1_data_i + imm_i;
      mem_data_q <= rs2_data_i;
    end
  end

  assign mem_req_o  = (state_q == EXEC_STORE);
  assign mem_addr_o = mem_addr_q;
  assign mem_data_o = mem_data_q;
  assign retire_o   = (state_q == EXEC_RETIRE);

  a_retire_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
    retire_o |=> !retire_o);

endmodule

`default_nettype wire

//--- hw/rv_fetch.sv
`default_nettype none

module rv_fetch import rv_pkg::*; #(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  retire_i,
  input  logic  inst_ack_i,
  input  word_t inst_data_i,
  output logic  inst_stb_o,
  output word_t inst_adr_o,
  output logic  inst_vld_o,
  output word_t inst_word_o
);

  fetch_state_e state_q;
  word_t        pc_q;
  word_t        inst_word_q;
  logic         inst_vld_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q    <= FETCH_REQ;
      pc_q       <= RESET_PC;
      inst_vld_q <= 1'b0;
    end else begin
      inst_vld_q <= 1'b0;
      case (state_q)
        FETCH_REQ: begin
          state_q <= FETCH_WAIT; // First fetch after reset
        end
        FETCH_WAIT: begin
          if (inst_ack_i) begin
            inst_vld_q <= 1'b1;
            state_q    <= FETCH_HOLD;
          end
        end
        FETCH_HOLD: begin
          if (retire_i) begin
            pc_q    <= pc_q + 32'd4;
            state_q <= FETCH_WAIT;
          end
        end
        default: begin
          state_q <= FETCH_REQ;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (inst_stb_o && inst_ack_i) begin
      inst_word_q <= inst_data_i;
    end
  end

  assign inst_stb_o  = (state_q == FETCH_WAIT);
  assign inst_adr_o  = pc_q;
  assign inst_vld_o  = inst_vld_q;
  assign inst_word_o = inst_word_q;

  // The memory sees a stable request until it answers
  a_stb_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    inst_stb_o && !inst_ack_i |=> inst_stb_o && $stable(inst_adr_o));

endmodule

`default_nettype wire

//--- hw/rv_pkg.sv
`default_nettype none

package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [63:0] dword_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [11:0] csr_addr_t;

  typedef enum logic [1:0] {
    FETCH_REQ,
    FETCH_WAIT,
    FETCH_HOLD
  } fetch_state_e;

  typedef enum logic [1:0] {
    EXEC_IDLE,
    EXEC_STORE,
    EXEC_RETIRE
  } exec_state_e;

  typedef enum logic [2:0] {
    OP_ALU_IMM,
    OP_ALU_REG,
    OP_LUI,
    OP_STORE,
    OP_CSR_READ,
    OP_NOP
  } op_class_e;

  // ========================================
  // Opcodes and funct3 codes
  // ========================================
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  localparam logic [2:0] F3_ADD   = 3'b000; // ADD, SUB, ADDI
  localparam logic [2:0] F3_SLL   = 3'b001;
  localparam logic [2:0] F3_SLT   = 3'b010;
  localparam logic [2:0] F3_SLTU  = 3'b011;
  localparam logic [2:0] F3_XOR   = 3'b100;
  localparam logic [2:0] F3_SR    = 3'b101; // Logical or arithmetic by bit 30
  localparam logic [2:0] F3_OR    = 3'b110;
  localparam logic [2:0] F3_AND   = 3'b111;
  localparam logic [2:0] F3_SW    = 3'b010;
  localparam logic [2:0] F3_CSRRS = 3'b010;

  localparam csr_addr_t CSR_MCYCLE    = 12'hB00;
  localparam csr_addr_t CSR_MCYCLEH   = 12'hB80;
  localparam csr_addr_t CSR_MINSTRET  = 12'hB02;
  localparam csr_addr_t CSR_MINSTRETH = 12'hB82;

endpackage

`default_nettype wire

//--- hw/rv_regfile.sv
`default_nettype none

module rv_regfile import rv_pkg::*; (
  input  logic      clk,
  input  reg_addr_t rs1_i,
  input  reg_addr_t rs2_i,
  input  logic      we_i,
  input  reg_addr_t wr_addr_i,
  input  word_t     wr_data_i,
  output word_t     rs1_data_o,
  output word_t     rs2_data_o
);

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (we_i && wr_addr_i != 5'd0) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  // x0 is hardwired
  assign rs1_data_o = (rs1_i == 5'd0) ? 32'd0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == 5'd0) ? 32'd0 : regs[rs2_i];

endmodule

`default_nettype wire

//--- verification/tb_rv_core.sv
`default_nettype none

module tb_rv_core;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] RESET_PC     = 32'h0000_0000;
  localparam logic [31:0] STORE_BASE   = 32'h0000_1000; // x10 after the LUI
  localparam int          HALF_PERIOD  = 20;
  localparam int          RESET_CYCLES = 10;
  localparam logic [31:0] SEED         = 32'd66636;

  logic        clk         = 1'b0;
  logic        rst_n_i     = 1'b0;
  logic        inst_ack_i  = 1'b0;
  logic [31:0] inst_data_i = 32'd0;
  logic        mem_ack_i   = 1'b0;
  logic        inst_stb_o;
  logic [31:0] inst_adr_o;
  logic        mem_req_o;
  logic [31:0] mem_addr_o;
  logic [31:0] mem_data_o;

  // Program table, one row per instruction word
  logic [31:0] prog_inst [$];
  logic        prog_st   [$];
  logic [31:0] prog_addr [$];
  logic [31:0] prog_data [$];
  logic        prog_ctr  [$]; // Data is a counter that must grow

  bit          table_built = 1'b0;
  int          n_stores    = 0;
  int          stores_seen = 0;
  int          st_ptr      = 0;
  logic [31:0] last_ctr    = 32'd0;
  logic [31:0] exp_pc      = RESET_PC;
  logic [31:0] inst_rng    = SEED;
  logic [31:0] mem_rng     = SEED ^ 32'h5bd1_e995;
  bit          inst_busy   = 1'b0;
  bit          mem_busy    = 1'b0;
  int          inst_wait   = 0;
  int          mem_wait    = 0;

  rv_core_top #(.RESET_PC(RESET_PC)) dut (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .inst_ack_i (inst_ack_i),
    .inst_data_i(inst_data_i),
    .mem_ack_i  (mem_ack_i),
    .inst_stb_o (inst_stb_o),
    .inst_adr_o (inst_adr_o),
    .mem_req_o  (mem_req_o),
    .mem_addr_o (mem_addr_o),
    .mem_data_o (mem_data_o)
  );

  initial begin
    forever #HALF_PERIOD clk = ~clk;
  end

  // ========================================
  // Helpers
  // ========================================
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] op_imm(input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] op_reg(input logic [2:0] f3, input logic alt,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {1'b0, alt, 5'd0, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] sw_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [11:0] off);
    return {off[11:5], rs2, rs1, 3'b010, off[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] csr_read(input logic [4:0] rd, input logic [11:0] csr);
    return {csr, 5'd0, 3'b010, rd, 7'b1110011}; // CSRRS rd, csr, x0
  endfunction

  function automatic logic [31:0] fetch_word(input logic [31:0] pc);
    int idx;
    idx = int'((pc - RESET_PC) >> 2);
    if (idx < prog_inst.size()) begin
      return prog_inst[idx];
    end
    return 32'h0000_0013; // ADDI x0, x0, 0
  endfunction

  task automatic add_row(input logic [31:0] inst, input logic st, input logic [31:0] addr,
                         input logic [31:0] data, input logic ctr);
    prog_inst.push_back(inst);
    prog_st.push_back(st);
    prog_addr.push_back(addr);
    prog_data.push_back(data);
    prog_ctr.push_back(ctr);
  endtask

  task automatic add_store(input logic [4:0] rs2, input logic [11:0] off,
                           input logic [31:0] data, input logic ctr);
    add_row(sw_word(rs2, 5'd10, off), 1'b1, STORE_BASE + {{20{off[11]}}, off}, data, ctr);
  endtask

  task automatic add_checked(input logic [31:0] inst, input logic [4:0] rd,
                             input logic [11:0] off, input logic [31:0] data);
    add_row(inst, 1'b0, 32'd0, 32'd0, 1'b0);
    add_store(rd, off, data, 1'b0);
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic compare_word(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0d ns: %s is 0x%08h, expected 0x%08h",
                          $time, what, got, exp));
    end
  endtask

  // ========================================
  // Program
  // ========================================
  task automatic build_program();
    add_row(op_imm(3'b000, 5'd1, 5'd0, 12'd100), 1'b0, 32'd0, 32'd0, 1'b0);  // x1 = 100
    add_row(op_imm(3'b000, 5'd2, 5'd0, 12'hFF9), 1'b0, 32'd0, 32'd0, 1'b0);  // x2 = -7
    add_row(lui_word(5'd10, 20'h00001), 1'b0, 32'd0, 32'd0, 1'b0);
    add_row(op_imm(3'b000, 5'd4, 5'd0, 12'd31), 1'b0, 32'd0, 32'd0, 1'b0);
    add_row(op_imm(3'b000, 5'd5, 5'd0, 12'd33), 1'b0, 32'd0, 32'd0, 1'b0);   // Shifts by 1
    add_store(5'd1, 12'd0, 32'd100, 1'b0);
    add_store(5'd2, 12'd4, 32'hFFFF_FFF9, 1'b0);
    add_checked(op_imm(3'b100, 5'd3, 5'd1, 12'h0F0), 5'd3, 12'd8, 32'h0000_0094);  // XORI
    add_checked(op_imm(3'b110, 5'd3, 5'd1, 12'h703), 5'd3, 12'd12, 32'h0000_0767); // ORI
    add_checked(op_imm(3'b111, 5'd3, 5'd2, 12'h0FF), 5'd3, 12'd16, 32'h0000_00F9); // ANDI
    add_checked(op_imm(3'b010, 5'd3, 5'd2, 12'hFFF), 5'd3, 12'd20, 32'd1);         // SLTI
    add_checked(op_imm(3'b011, 5'd3, 5'd2, 12'd5), 5'd3, 12'd24, 32'd0);           // SLTIU
    add_checked(op_imm(3'b001, 5'd3, 5'd1, 12'd4), 5'd3, 12'd28, 32'h0000_0640);   // SLLI
    add_checked(op_imm(3'b101, 5'd3, 5'd2, 12'd4), 5'd3, 12'd32, 32'h0FFF_FFFF);   // SRLI
    add_checked(op_imm(3'b101, 5'd3, 5'd2, 12'h401), 5'd3, 12'd36, 32'hFFFF_FFFC); // SRAI
    add_checked(op_reg(3'b000, 1'b0, 5'd6, 5'd1, 5'd2), 5'd6, 12'd40, 32'h0000_005D); // ADD
    add_checked(op_reg(3'b000, 1'b1, 5'd6, 5'd2, 5'd1), 5'd6, 12'd44, 32'hFFFF_FF95); // SUB
    add_checked(op_reg(3'b001, 1'b0, 5'd6, 5'd2, 5'd4), 5'd6, 12'd48, 32'h8000_0000); // SLL
    add_checked(op_reg(3'b010, 1'b0, 5'd6, 5'd2, 5'd1), 5'd6, 12'd52, 32'd1);         // SLT
    add_checked(op_reg(3'b011, 1'b0, 5'd6, 5'd2, 5'd1), 5'd6, 12'd56, 32'd0);         // SLTU
    add_checked(op_reg(3'b100, 1'b0, 5'd6, 5'd1, 5'd2), 5'd6, 12'd60, 32'hFFFF_FF9D); // XOR
    add_checked(op_reg(3'b101, 1'b0, 5'd6, 5'd2, 5'd4), 5'd6, 12'd64, 32'd1);         // SRL
    add_checked(op_reg(3'b101, 1'b1, 5'd6, 5'd2, 5'd4), 5'd6, 12'd68, 32'hFFFF_FFFF); // SRA
    add_checked(op_reg(3'b110, 1'b0, 5'd6, 5'd1, 5'd2), 5'd6, 12'd72, 32'hFFFF_FFFD); // OR
    add_checked(op_reg(3'b111, 1'b0, 5'd6, 5'd1, 5'd2), 5'd6, 12'd76, 32'h0000_0060); // AND
    add_checked(op_reg(3'b101, 1'b0, 5'd6, 5'd1, 5'd5), 5'd6, 12'd80, 32'h0000_0032);
    add_checked(lui_word(5'd7, 20'hABCDE), 5'd7, 12'd84, 32'hABCD_E000);
    add_row(op_imm(3'b000, 5'd0, 5'd0, 12'd123), 1'b0, 32'd0, 32'd0, 1'b0);  // Write to x0
    add_store(5'd0, 12'd88, 32'd0, 1'b0);
    // minstret equals the row index of the read
    add_checked(csr_read(5'd8, 12'hB02), 5'd8, 12'd92, 32'(prog_inst.size()));
    add_row(csr_read(5'd9, 12'hB00), 1'b0, 32'd0, 32'd0, 1'b0);
    add_store(5'd9, 12'd96, 32'd0, 1'b1);
    add_row(csr_read(5'd9, 12'hB00), 1'b0, 32'd0, 32'd0, 1'b0);
    add_store(5'd9, 12'd100, 32'd0, 1'b1);
    add_checked(csr_read(5'd12, 12'hB80), 5'd12, 12'd104, 32'd0);  // mcycleh
    add_checked(csr_read(5'd8, 12'hB02), 5'd8, 12'd108, 32'(prog_inst.size()));
    add_store(5'd1, 12'hFF8, 32'd100, 1'b0); // Negative offset
  endtask

  // ========================================
  // Bus models
  // ========================================
  always @(posedge clk) begin
    if (!rst_n_i) begin
      inst_ack_i <= 1'b0;
      inst_busy = 1'b0;
    end else if (inst_ack_i) begin
      compare_word(inst_adr_o, exp_pc, "fetch address");
      exp_pc = exp_pc + 32'd4;
      inst_ack_i <= 1'b0;
      inst_busy = 1'b0;
    end else if (inst_stb_o) begin
      if (!inst_busy) begin
        inst_busy = 1'b1;
        inst_rng  = xorshift(inst_rng);
        inst_wait = int'(inst_rng[1:0]);
      end
      if (inst_wait == 0) begin
        inst_ack_i  <= 1'b1;
        inst_data_i <= fetch_word(inst_adr_o);
      end else begin
        inst_wait = inst_wait - 1;
      end
    end
  end

  always @(posedge clk) begin
    if (!rst_n_i) begin
      mem_ack_i <= 1'b0;
      mem_busy = 1'b0;
    end else if (mem_ack_i) begin
      while (st_ptr < prog_st.size() && !prog_st[st_ptr]) begin
        st_ptr = st_ptr + 1;
      end
      if (st_ptr >= prog_st.size()) begin
        abort_run("The core wrote to the data bus after the last expected store");
      end else begin
        compare_word(mem_addr_o, prog_addr[st_ptr], "store address");
        if (prog_ctr[st_ptr]) begin
          compare_word({31'd0, mem_data_o > last_ctr}, 32'd1, "mcycle growth");
          last_ctr = mem_data_o;
        end else begin
          compare_word(mem_data_o, prog_data[st_ptr], "store data");
        end
        st_ptr      = st_ptr + 1;
        stores_seen = stores_seen + 1;
      end
      mem_ack_i <= 1'b0;
      mem_busy = 1'b0;
    end else if (mem_req_o) begin
      if (!mem_busy) begin
        mem_busy = 1'b1;
        mem_rng  = xorshift(mem_rng);
        mem_wait = int'(mem_rng[1:0]);
      end
      if (mem_wait == 0) begin
        mem_ack_i <= 1'b1;
      end else begin
        mem_wait = mem_wait - 1;
      end
    end
  end

  // ========================================
  // Run control
  // ========================================
  initial begin
    wait (table_built);
    repeat (RESET_CYCLES + 100 * prog_inst.size()) @(posedge clk);
    abort_run("Timeout: the core stalled before the last expected store");
  end

  initial begin
    build_program();
    foreach (prog_st[i]) begin
      if (prog_st[i]) begin
        n_stores = n_stores + 1;
      end
    end
    table_built = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n_i <= 1'b1;
    wait (stores_seen == n_stores);
    repeat (20) @(posedge clk); // Trailing no-ops must not store
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire
